/* flist.f */
+incdir+hw
hw/axi_pkg.sv
hw/cache_req_pkg.sv
hw/read_port_arbiter.sv
hw/axi_read_engine.sv
hw/line_collector.sv
hw/axi_write_engine.sv
hw/line_serializer.sv
hw/cache_axi_bridge.sv
verification/axi_mem_model.sv
verification/tb_cache_axi_bridge.sv

/* hw/axi_pkg.sv */
`include "bridge_defines.svh"

package axi_pkg;

    localparam logic [1:0] AXI_BURST_INCR = 2'b01;           // incrementing burst
    localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;          // 4 bytes per beat
    localparam logic [7:0] AXI_LEN_LINE   = 8'(`BRIDGE_LINE_BEATS - 1); // one full line

    // read address channel
    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0]   id;
        logic [`BRIDGE_ADDR_W-1:0] addr;
        logic [7:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
    } axi_ar_t;

    // write address channel carries no id since writes are never interleaved
    typedef struct packed {
        logic [`BRIDGE_ADDR_W-1:0] addr;
        logic [7:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
    } axi_aw_t;

    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0]   id;
        logic [`BRIDGE_BEAT_W-1:0] data;
        logic                      last;
    } axi_r_t;

    typedef struct packed {
        logic [`BRIDGE_BEAT_W-1:0]   data;
        logic [`BRIDGE_BEAT_W/8-1:0] strb;
        logic                        last;
    } axi_w_t;

endpackage

/* hw/axi_read_engine.sv */
`timescale 1ns/1ps
`include "bridge_defines.svh"

module axi_read_engine (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  cache_req_pkg::rd_grant_t    i_grant,
    output axi_pkg::axi_ar_t            o_ar,
    output logic                        o_ar_valid,
    input  logic                        i_ar_ready,
    input  axi_pkg::axi_r_t             i_r,
    input  logic                        i_r_valid,
    output logic                        o_r_ready,
    output logic                        o_beat_take,
    output logic [`BRIDGE_BEAT_W-1:0]   o_beat_data,
    output logic                        o_burst_end
);

    typedef enum logic [1:0] {
        rd_idle,
        rd_addr,
        rd_data
    } rd_state_e;

    rd_state_e                                state_q;
    rd_state_e                                state_d;
    logic [$clog2(`BRIDGE_LINE_BEATS)-1:0]    beat_cnt;
    logic                                     grant_new;
    logic                                     ar_fire;
    logic                                     r_fire;

    assign grant_new = i_grant.valid && !o_burst_end;        // stale grant during done cycle
    assign ar_fire   = o_ar_valid && i_ar_ready;
    assign r_fire    = i_r_valid && o_r_ready;

    assign o_ar.id    = `BRIDGE_ID_W'(i_grant.owner);
    assign o_ar.addr  = i_grant.addr;
    assign o_ar.len   = axi_pkg::AXI_LEN_LINE;
    assign o_ar.size  = axi_pkg::AXI_SIZE_WORD;
    assign o_ar.burst = axi_pkg::AXI_BURST_INCR;

    assign o_ar_valid  = (state_q == rd_idle && grant_new) || state_q == rd_addr;
    assign o_r_ready   = (state_q == rd_data);
    assign o_beat_take = r_fire;
    assign o_beat_data = i_r.data;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            rd_idle:
                if (grant_new)
                    state_d = i_ar_ready ? rd_data : rd_addr;
            rd_addr:
                if (ar_fire)
                    state_d = rd_data;
            rd_data:
                if (r_fire && i_r.last)
                    state_d = rd_idle;
            default:
                state_d = rd_idle;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            state_q     <= rd_idle;
            beat_cnt    <= '0;
            o_burst_end <= 1'b0;
        end
        else
        begin
            state_q     <= state_d;
            o_burst_end <= r_fire && i_r.last;               // one cycle after last beat
            if (ar_fire)
                beat_cnt <= '0;
            else if (r_fire)
                beat_cnt <= beat_cnt + 1'b1;
        end
    end

    a_last_on_16th: assert property (@(posedge aclk) disable iff (!aresetn)
        r_fire |-> (i_r.last == (beat_cnt == $clog2(`BRIDGE_LINE_BEATS)'(`BRIDGE_LINE_BEATS - 1))));

    a_rid_owner: assert property (@(posedge aclk) disable iff (!aresetn)
        r_fire |-> (i_r.id == `BRIDGE_ID_W'(i_grant.owner)));

endmodule

/* hw/axi_write_engine.sv */
`timescale 1ns/1ps
`include "bridge_defines.svh"

module axi_write_engine (
    input  logic                          aclk,
    input  logic                          aresetn,
    input  logic                          i_wr_req,
    input  logic [`BRIDGE_ADDR_W-1:0]     i_wr_addr,
    input  logic [`BRIDGE_BEAT_W/8-1:0]   i_wr_strb,
    output logic                          o_load,
    output logic                          o_advance,
    input  logic [`BRIDGE_BEAT_W-1:0]     i_beat_data,
    output axi_pkg::axi_aw_t              o_aw,
    output logic                          o_aw_valid,
    input  logic                          i_aw_ready,
    output axi_pkg::axi_w_t               o_w,
    output logic                          o_w_valid,
    input  logic                          i_w_ready,
    input  logic                          i_b_valid,
    output logic                          o_b_ready,
    output logic                          o_wr_done
);

    typedef enum logic [1:0] {
        wr_idle,
        wr_addr,
        wr_data,
        wr_resp
    } wr_state_e;

    wr_state_e   state_q;
    wr_state_e   state_d;
    logic [3:0]  beat_cnt;
    logic        aw_fire;
    logic        w_fire;
    logic        b_fire;

    assign aw_fire = o_aw_valid && i_aw_ready;
    assign w_fire  = o_w_valid && i_w_ready;
    assign b_fire  = i_b_valid && o_b_ready;

    assign o_load     = (state_q == wr_idle) && i_wr_req && !o_wr_done; // request still up on done
    assign o_advance  = w_fire;
    assign o_aw_valid = (state_q == wr_addr);
    assign o_w_valid  = (state_q == wr_data);
    assign o_b_ready  = (state_q == wr_resp);

    assign o_aw.addr  = i_wr_addr;
    assign o_aw.len   = axi_pkg::AXI_LEN_LINE;
    assign o_aw.size  = axi_pkg::AXI_SIZE_WORD;
    assign o_aw.burst = axi_pkg::AXI_BURST_INCR;

    assign o_w.data = i_beat_data;
    assign o_w.strb = i_wr_strb;                             // same mask on all beats
    assign o_w.last = (beat_cnt == 4'd15);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            wr_idle:
                if (o_load)
                    state_d = wr_addr;
            wr_addr:
                if (aw_fire)
                    state_d = wr_data;
            wr_data:
                if (w_fire && o_w.last)
                    state_d = wr_resp;
            wr_resp:
                if (b_fire)
                    state_d = wr_idle;
            default:
                state_d = wr_idle;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            state_q   <= wr_idle;
            beat_cnt  <= 4'd0;
            o_wr_done <= 1'b0;
        end
        else
        begin
            state_q   <= state_d;
            o_wr_done <= b_fire;
            if (o_load)
                beat_cnt <= 4'd0;
            else if (w_fire)
                beat_cnt <= beat_cnt + 4'd1;                 // wraps after beat 15
        end
    end

    a_w_after_aw: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(o_w_valid) |-> $past(aw_fire));

endmodule

/* hw/bridge_defines.svh */
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// byte address width on both the cache and the AXI side
`define BRIDGE_ADDR_W 32

// width of one AXI data beat
`define BRIDGE_BEAT_W 32

// beats in one cache line
`define BRIDGE_LINE_BEATS 16

// full cache line is beats times beat width
`define BRIDGE_LINE_W 512

// AXI id width where only ids 0 and 1 are driven
`define BRIDGE_ID_W 4

`endif

/* hw/cache_axi_bridge.sv */
`timescale 1ns/1ps
`include "bridge_defines.svh"

module cache_axi_bridge (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  logic                        i_ic_rd_req,
    input  cache_req_pkg::line_rd_req_t i_ic_rd_addr,
    output logic [`BRIDGE_LINE_W-1:0]   o_ic_rd_line,
    output logic                        o_ic_rd_done,
    input  logic                        i_dc_rd_req,
    input  cache_req_pkg::line_rd_req_t i_dc_rd_addr,
    output logic [`BRIDGE_LINE_W-1:0]   o_dc_rd_line,
    output logic                        o_dc_rd_done,
    input  logic                        i_dc_wr_req,
    input  cache_req_pkg::line_wr_req_t i_dc_wr,
    output logic                        o_dc_wr_done,
    output axi_pkg::axi_ar_t            o_ar,
    output logic                        o_ar_valid,
    input  logic                        i_ar_ready,
    input  axi_pkg::axi_r_t             i_r,
    input  logic                        i_r_valid,
    output logic                        o_r_ready,
    output axi_pkg::axi_aw_t            o_aw,
    output logic                        o_aw_valid,
    input  logic                        i_aw_ready,
    output axi_pkg::axi_w_t             o_w,
    output logic                        o_w_valid,
    input  logic                        i_w_ready,
    input  logic                        i_b_valid,
    output logic                        o_b_ready
);

    cache_req_pkg::rd_grant_t          rd_grant;
    logic                              burst_end;
    logic                              beat_take;
    logic [`BRIDGE_BEAT_W-1:0]         beat_data;
    logic [`BRIDGE_LINE_W-1:0]         rd_line;
    logic                              wr_load;
    logic                              wr_advance;
    logic [`BRIDGE_BEAT_W-1:0]         wr_beat;

    read_port_arbiter u_arbiter (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_ic_req    (i_ic_rd_req),
        .i_ic_addr   (i_ic_rd_addr),
        .i_dc_req    (i_dc_rd_req),
        .i_dc_addr   (i_dc_rd_addr),
        .i_burst_end (burst_end),
        .o_grant     (rd_grant)
    );

    axi_read_engine u_rd_engine (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_grant     (rd_grant),
        .o_ar        (o_ar),
        .o_ar_valid  (o_ar_valid),
        .i_ar_ready  (i_ar_ready),
        .i_r         (i_r),
        .i_r_valid   (i_r_valid),
        .o_r_ready   (o_r_ready),
        .o_beat_take (beat_take),
        .o_beat_data (beat_data),
        .o_burst_end (burst_end)
    );

    line_collector u_collector (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_beat_take (beat_take),
        .i_beat_data (beat_data),
        .o_line      (rd_line)
    );

    axi_write_engine u_wr_engine (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_wr_req    (i_dc_wr_req),
        .i_wr_addr   (i_dc_wr.addr),
        .i_wr_strb   (i_dc_wr.strb),
        .o_load      (wr_load),
        .o_advance   (wr_advance),
        .i_beat_data (wr_beat),
        .o_aw        (o_aw),
        .o_aw_valid  (o_aw_valid),
        .i_aw_ready  (i_aw_ready),
        .o_w         (o_w),
        .o_w_valid   (o_w_valid),
        .i_w_ready   (i_w_ready),
        .i_b_valid   (i_b_valid),
        .o_b_ready   (o_b_ready),
        .o_wr_done   (o_dc_wr_done)
    );

    line_serializer u_serializer (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_load    (wr_load),
        .i_line    (i_dc_wr.line),
        .i_advance (wr_advance),
        .o_beat    (wr_beat)
    );

    assign o_ic_rd_line = rd_line;                           // one line register serves both
    assign o_dc_rd_line = rd_line;

    // grant owner still valid on the burst end cycle
    assign o_ic_rd_done = burst_end && (rd_grant.owner == cache_req_pkg::OWNER_ICACHE);
    assign o_dc_rd_done = burst_end && (rd_grant.owner == cache_req_pkg::OWNER_DCACHE);

endmodule

/* hw/cache_req_pkg.sv */
`include "bridge_defines.svh"

package cache_req_pkg;

    typedef struct packed {
        logic [`BRIDGE_ADDR_W-1:0] addr;                     // line address
    } line_rd_req_t;

    typedef struct packed {
        logic [`BRIDGE_ADDR_W-1:0]   addr;
        logic [`BRIDGE_BEAT_W/8-1:0] strb;                   // same strobe on every beat
        logic [`BRIDGE_LINE_W-1:0]   line;
    } line_wr_req_t;

    // value doubles as the AXI read id
    typedef enum logic {
        OWNER_ICACHE = 1'b0,
        OWNER_DCACHE = 1'b1
    } read_owner_e;

    typedef struct packed {
        logic                      valid;
        read_owner_e               owner;
        logic [`BRIDGE_ADDR_W-1:0] addr;
    } rd_grant_t;

endpackage

/* hw/line_collector.sv */
`timescale 1ns/1ps
`include "bridge_defines.svh"

module line_collector (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  logic                        i_beat_take,
    input  logic [`BRIDGE_BEAT_W-1:0]   i_beat_data,
    output logic [`BRIDGE_LINE_W-1:0]   o_line
);

    // new beats enter at the top and move down, so after a full
    // burst the first beat sits in the lowest word
    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            o_line <= '0;
        end
        else if (i_beat_take)
        begin
            o_line <= {i_beat_data, o_line[`BRIDGE_LINE_W-1:`BRIDGE_BEAT_W]};
        end
    end

endmodule

/* hw/line_serializer.sv */
`timescale 1ns/1ps
`include "bridge_defines.svh"

module line_serializer (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  logic                        i_load,
    input  logic [`BRIDGE_LINE_W-1:0]   i_line,
    input  logic                        i_advance,
    output logic [`BRIDGE_BEAT_W-1:0]   o_beat
);

    logic [`BRIDGE_LINE_W-1:0] line_q;

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            line_q <= '0;
        end
        else if (i_load)
        begin
            line_q <= i_line;
        end
        else if (i_advance)
        begin
            // next word drops into the low slot
            line_q <= {{`BRIDGE_BEAT_W{1'b0}}, line_q[`BRIDGE_LINE_W-1:`BRIDGE_BEAT_W]};
        end
    end

    assign o_beat = line_q[`BRIDGE_BEAT_W-1:0];              // current beat

endmodule

/* hw/read_port_arbiter.sv */
`timescale 1ns/1ps
`include "bridge_defines.svh"

module read_port_arbiter (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  logic                        i_ic_req,
    input  cache_req_pkg::line_rd_req_t i_ic_addr,
    input  logic                        i_dc_req,
    input  cache_req_pkg::line_rd_req_t i_dc_addr,
    input  logic                        i_burst_end,
    output cache_req_pkg::rd_grant_t    o_grant
);

    always_ff @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            o_grant <= '0;
        end
        else if (o_grant.valid)
        begin
            if (i_burst_end)
                o_grant.valid <= 1'b0;                       // owner kept for done decode
        end
        else if (i_dc_req)
        begin
            o_grant.valid <= 1'b1;                           // data cache has priority
            o_grant.owner <= cache_req_pkg::OWNER_DCACHE;
            o_grant.addr  <= i_dc_addr.addr;
        end
        else if (i_ic_req)
        begin
            o_grant.valid <= 1'b1;
            o_grant.owner <= cache_req_pkg::OWNER_ICACHE;
            o_grant.addr  <= i_ic_addr.addr;
        end
    end

    // grant stays put for the whole burst
    a_grant_held: assert property (@(posedge aclk) disable iff (!aresetn)
        (o_grant.valid && !i_burst_end) |=> (o_grant.valid && $stable(o_grant)));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module tb_cache_axi_bridge \
    -o sim_tb

sim_out=$(./obj_dir/sim_tb 2>&1) || true
echo "$sim_out"

if grep -q "^TEST RESULT: PASS$" <<< "$sim_out"; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi

/* verification/axi_mem_model.sv */
`timescale 1ns/1ps
`include "bridge_defines.svh"

module axi_mem_model (
    input  logic             aclk,
    input  logic             aresetn,
    input  axi_pkg::axi_ar_t i_ar,
    input  logic             i_ar_valid,
    output logic             o_ar_ready,
    output axi_pkg::axi_r_t  o_r,
    output logic             o_r_valid,
    input  logic             i_r_ready,
    input  axi_pkg::axi_aw_t i_aw,
    input  logic             i_aw_valid,
    output logic             o_aw_ready,
    input  axi_pkg::axi_w_t  i_w,
    input  logic             i_w_valid,
    output logic             o_w_ready,
    output logic             o_b_valid,
    input  logic             i_b_ready
);

    logic [`BRIDGE_BEAT_W-1:0] mem [logic [29:0]];           // only words written so far
    logic                      rd_busy;
    logic [`BRIDGE_ADDR_W-1:0] rd_addr;
    logic [`BRIDGE_ID_W-1:0]   rd_id;
    logic [3:0]                rd_cnt;
    logic                      wr_busy;
    logic [`BRIDGE_ADDR_W-1:0] wr_addr;
    logic                      b_pend;

    // contents of a word that was never written
    function automatic logic [31:0] init_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr[31:2]))
            return mem[addr[31:2]];
        return init_word(addr);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] word;
        word = old_word;
        for (int b = 0; b < 4; b++)
        begin
            if (strb[b])
                word[8*b +: 8] = new_word[8*b +: 8];
        end
        return word;
    endfunction

    always @(posedge aclk or negedge aresetn)
    begin
        if (!aresetn)
        begin
            o_ar_ready <= 1'b0;
            o_r        <= '0;
            o_r_valid  <= 1'b0;
            o_aw_ready <= 1'b0;
            o_w_ready  <= 1'b0;
            o_b_valid  <= 1'b0;
            rd_busy    <= 1'b0;
            rd_addr    <= '0;
            rd_id      <= '0;
            rd_cnt     <= 4'd0;
            wr_busy    <= 1'b0;
            wr_addr    <= '0;
            b_pend     <= 1'b0;
        end
        else
        begin
            if (i_ar_valid && o_ar_ready)
            begin
                rd_busy    <= 1'b1;                          // one read burst at a time
                rd_addr    <= i_ar.addr;
                rd_id      <= i_ar.id;
                rd_cnt     <= 4'd0;
                o_ar_ready <= 1'b0;
            end
            else
                o_ar_ready <= !rd_busy && (($urandom % 3) == 0);

            if (o_r_valid && i_r_ready)
            begin
                o_r_valid <= 1'b0;
                rd_addr   <= rd_addr + 32'd4;
                rd_cnt    <= rd_cnt + 4'd1;
                if (o_r.last)
                    rd_busy <= 1'b0;
            end
            else if (rd_busy && !o_r_valid && (($urandom % 4) != 0))
            begin
                o_r_valid <= 1'b1;                           // held until taken
                o_r.id    <= rd_id;
                o_r.data  <= read_word(rd_addr);
                o_r.last  <= (rd_cnt == 4'd15);
            end

            if (i_aw_valid && o_aw_ready)
            begin
                wr_busy    <= 1'b1;
                wr_addr    <= i_aw.addr;
                o_aw_ready <= 1'b0;
            end
            else
                o_aw_ready <= !wr_busy && !b_pend && !o_b_valid && (($urandom % 3) == 0);

            if (i_w_valid && o_w_ready)
            begin
                mem[wr_addr[31:2]] = merge_bytes(read_word(wr_addr), i_w.data, i_w.strb);
                wr_addr   <= wr_addr + 32'd4;
                o_w_ready <= 1'b0;
                if (i_w.last)
                begin
                    wr_busy <= 1'b0;
                    b_pend  <= 1'b1;
                end
            end
            else
                o_w_ready <= wr_busy && (($urandom % 2) == 0);

            if (o_b_valid && i_b_ready)
                o_b_valid <= 1'b0;
            else if (b_pend && !o_b_valid && (($urandom % 3) != 0))
            begin
                o_b_valid <= 1'b1;
                b_pend    <= 1'b0;
            end
        end
    end

endmodule

/* verification/tb_cache_axi_bridge.sv */
`timescale 1ns/1ps
`include "bridge_defines.svh"

module tb_cache_axi_bridge;

    localparam int WAIT_LIMIT = 3000;                        // cycles per table entry
    localparam int NUM_OPS    = 12;

    typedef enum logic [1:0] {
        OP_IC_RD,
        OP_DC_RD,
        OP_WRITE,
        OP_WR_RD                                             // write plus dcache read elsewhere
    } op_kind_e;

    typedef struct packed {
        op_kind_e                    kind;
        logic [`BRIDGE_ADDR_W-1:0]   addr;
        logic [31:0]                 seed;                   // write line seed
        logic [`BRIDGE_BEAT_W/8-1:0] strb;
        logic                        both;                   // icache read raised too
    } op_entry_t;

    logic                        aclk;
    logic                        aresetn;
    logic                        ic_rd_req;
    cache_req_pkg::line_rd_req_t ic_rd_addr;
    logic [`BRIDGE_LINE_W-1:0]   ic_rd_line;
    logic                        ic_rd_done;
    logic                        dc_rd_req;
    cache_req_pkg::line_rd_req_t dc_rd_addr;
    logic [`BRIDGE_LINE_W-1:0]   dc_rd_line;
    logic                        dc_rd_done;
    logic                        dc_wr_req;
    cache_req_pkg::line_wr_req_t dc_wr;
    logic                        dc_wr_done;
    axi_pkg::axi_ar_t            ar;
    logic                        ar_valid;
    logic                        ar_ready;
    axi_pkg::axi_r_t             r;
    logic                        r_valid;
    logic                        r_ready;
    axi_pkg::axi_aw_t            aw;
    logic                        aw_valid;
    logic                        aw_ready;
    axi_pkg::axi_w_t             w;
    logic                        w_valid;
    logic                        w_ready;
    logic                        b_valid;
    logic                        b_ready;
    axi_pkg::axi_ar_t            last_ar;
    axi_pkg::axi_aw_t            last_aw;
    logic [31:0]                 exp_mem [logic [29:0]];    // expected copy of written words
    op_entry_t                   ops [NUM_OPS];
    int                          entry_idx;

    cache_axi_bridge DUT (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_ic_rd_req  (ic_rd_req),
        .i_ic_rd_addr (ic_rd_addr),
        .o_ic_rd_line (ic_rd_line),
        .o_ic_rd_done (ic_rd_done),
        .i_dc_rd_req  (dc_rd_req),
        .i_dc_rd_addr (dc_rd_addr),
        .o_dc_rd_line (dc_rd_line),
        .o_dc_rd_done (dc_rd_done),
        .i_dc_wr_req  (dc_wr_req),
        .i_dc_wr      (dc_wr),
        .o_dc_wr_done (dc_wr_done),
        .o_ar         (ar),
        .o_ar_valid   (ar_valid),
        .i_ar_ready   (ar_ready),
        .i_r          (r),
        .i_r_valid    (r_valid),
        .o_r_ready    (r_ready),
        .o_aw         (aw),
        .o_aw_valid   (aw_valid),
        .i_aw_ready   (aw_ready),
        .o_w          (w),
        .o_w_valid    (w_valid),
        .i_w_ready    (w_ready),
        .i_b_valid    (b_valid),
        .o_b_ready    (b_ready)
    );

    axi_mem_model u_mem (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_ar       (ar),
        .i_ar_valid (ar_valid),
        .o_ar_ready (ar_ready),
        .o_r        (r),
        .o_r_valid  (r_valid),
        .i_r_ready  (r_ready),
        .i_aw       (aw),
        .i_aw_valid (aw_valid),
        .o_aw_ready (aw_ready),
        .i_w        (w),
        .i_w_valid  (w_valid),
        .o_w_ready  (w_ready),
        .o_b_valid  (b_valid),
        .i_b_ready  (b_ready)
    );

    always #2 aclk = ~aclk;

    // payloads of the most recent AR and AW transfers
    always @(posedge aclk)
    begin
        if (ar_valid && ar_ready)
            last_ar <= ar;
        if (aw_valid && aw_ready)
            last_aw <= aw;
    end

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        if (exp_mem.exists(addr[31:2]))
            return exp_mem[addr[31:2]];
        return fill_word(addr);
    endfunction

    // beat 0 in the low word
    function automatic logic [`BRIDGE_LINE_W-1:0] expected_line(input logic [31:0] addr);
        logic [`BRIDGE_LINE_W-1:0] line;
        int                        i;
        for (i = 0; i < 16; i++)
            line[32*i +: 32] = expected_word(addr + 32'(4 * i));
        return line;
    endfunction

    function automatic logic [`BRIDGE_LINE_W-1:0] line_from_seed(input logic [31:0] seed);
        logic [`BRIDGE_LINE_W-1:0] line;
        int                        i;
        for (i = 0; i < 16; i++)
            line[32*i +: 32] = seed ^ (32'h1111_1111 * 32'(i + 1));
        return line;
    endfunction

    // one line read as 16 incrementing beats of 4 bytes
    function automatic axi_pkg::axi_ar_t ar_for_line(input logic [3:0]  id,
                                                     input logic [31:0] addr);
        axi_pkg::axi_ar_t ar_exp;
        ar_exp.id    = id;
        ar_exp.addr  = addr;
        ar_exp.len   = 8'd15;
        ar_exp.size  = 3'b010;
        ar_exp.burst = 2'b01;
        return ar_exp;
    endfunction

    function automatic axi_pkg::axi_aw_t aw_for_line(input logic [31:0] addr);
        axi_pkg::axi_aw_t aw_exp;
        aw_exp.addr  = addr;
        aw_exp.len   = 8'd15;
        aw_exp.size  = 3'b010;
        aw_exp.burst = 2'b01;
        return aw_exp;
    endfunction

    // same strobe on every beat of the line
    task automatic apply_write(input logic [31:0] addr, input logic [`BRIDGE_LINE_W-1:0] line,
                               input logic [3:0] strb);
        logic [31:0] word;
        logic [31:0] beat_addr;
        int          i;
        int          b;
        for (i = 0; i < 16; i++)
        begin
            beat_addr = addr + 32'(4 * i);
            word      = expected_word(beat_addr);
            for (b = 0; b < 4; b++)
            begin
                if (strb[b])
                    word[8*b +: 8] = line[32*i + 8*b +: 8];
            end
            exp_mem[beat_addr[31:2]] = word;
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [`BRIDGE_LINE_W-1:0] expected,
                               input logic [`BRIDGE_LINE_W-1:0] actual);
        if (expected !== actual)
            fail_run($sformatf("CHECK FAILED %s %s expected %0h actual %0h",
                               name, what, expected, actual));
    endtask

    task automatic build_table();
        ops[0]  = '{OP_IC_RD, 32'h0000_1000, 32'h0000_0000, 4'h0, 1'b0};
        ops[1]  = '{OP_DC_RD, 32'h0000_2040, 32'h0000_0000, 4'h0, 1'b0};
        ops[2]  = '{OP_DC_RD, 32'h0000_3000, 32'h0000_0000, 4'h0, 1'b1};
        ops[3]  = '{OP_WRITE, 32'h0000_2040, 32'h1234_5678, 4'hf, 1'b0};
        ops[4]  = '{OP_DC_RD, 32'h0000_2040, 32'h0000_0000, 4'h0, 1'b0};
        ops[5]  = '{OP_WRITE, 32'h0000_2040, 32'hcafe_0042, 4'h5, 1'b0}; // partial strobe
        ops[6]  = '{OP_DC_RD, 32'h0000_2040, 32'h0000_0000, 4'h0, 1'b0};
        ops[7]  = '{OP_IC_RD, 32'h0000_2040, 32'h0000_0000, 4'h0, 1'b0};
        ops[8]  = '{OP_WR_RD, 32'h0000_8000, 32'h0bad_f00d, 4'ha, 1'b0};
        ops[9]  = '{OP_DC_RD, 32'h0000_8000, 32'h0000_0000, 4'h0, 1'b1};
        ops[10] = '{OP_WRITE, 32'hfffe_0000, 32'h5a5a_0001, 4'hf, 1'b0};
        ops[11] = '{OP_DC_RD, 32'hfffe_0000, 32'h0000_0000, 4'h0, 1'b1};
    endtask

    task automatic run_entry(input int idx, input op_entry_t op);
        logic                      want_ic;
        logic                      want_dc;
        logic                      want_wr;
        logic                      drop_ic;
        logic                      drop_dc;
        logic                      drop_wr;
        logic [31:0]               ic_addr;
        logic [31:0]               dc_addr;
        logic [`BRIDGE_LINE_W-1:0] wr_line;
        logic [`BRIDGE_LINE_W-1:0] exp_ic;
        logic [`BRIDGE_LINE_W-1:0] exp_dc;
        int                        cycles;
        string                     name;

        name    = $sformatf("entry %0d", idx);
        want_ic = (op.kind == OP_IC_RD) || (op.kind == OP_DC_RD && op.both);
        want_dc = (op.kind == OP_DC_RD) || (op.kind == OP_WR_RD);
        want_wr = (op.kind == OP_WRITE) || (op.kind == OP_WR_RD);
        ic_addr = (op.kind == OP_IC_RD) ? op.addr : op.addr + 32'h1000;
        dc_addr = (op.kind == OP_WR_RD) ? op.addr + 32'h1000 : op.addr;
        wr_line = line_from_seed(op.seed);
        exp_ic  = expected_line(ic_addr);
        exp_dc  = expected_line(dc_addr);

        @(posedge aclk);
        ic_rd_req       <= want_ic;
        ic_rd_addr.addr <= ic_addr;
        dc_rd_req       <= want_dc;
        dc_rd_addr.addr <= dc_addr;
        dc_wr_req       <= want_wr;
        dc_wr.addr      <= op.addr;
        dc_wr.strb      <= op.strb;
        dc_wr.line      <= wr_line;

        cycles = 0;
        while (want_ic || want_dc || want_wr)
        begin
            @(negedge aclk);                                 // outputs settled mid cycle
            cycles++;
            if (cycles > WAIT_LIMIT)
                fail_run($sformatf("%s timed out waiting for a done pulse", name));
            check_value(name, "unexpected icache done", 0, ic_rd_done && !want_ic);
            check_value(name, "unexpected dcache done", 0, dc_rd_done && !want_dc);
            check_value(name, "unexpected write done", 0, dc_wr_done && !want_wr);
            drop_ic = want_ic && ic_rd_done;
            drop_dc = want_dc && dc_rd_done;
            drop_wr = want_wr && dc_wr_done;
            if (drop_dc)
            begin
                check_value(name, "dcache line", exp_dc, dc_rd_line);
                check_value(name, "dcache ar", ar_for_line(4'd1, dc_addr), last_ar);
            end
            if (drop_ic)
            begin
                check_value(name, "icache line", exp_ic, ic_rd_line);
                check_value(name, "icache ar", ar_for_line(4'd0, ic_addr), last_ar);
                check_value(name, "dcache served first", 0, want_dc);
            end
            if (drop_wr)
            begin
                check_value(name, "write aw", aw_for_line(op.addr), last_aw);
                apply_write(op.addr, wr_line, op.strb);
            end
            want_ic = want_ic && !drop_ic;
            want_dc = want_dc && !drop_dc;
            want_wr = want_wr && !drop_wr;
            @(posedge aclk);
            if (drop_ic)
                ic_rd_req <= 1'b0;
            if (drop_dc)
                dc_rd_req <= 1'b0;
            if (drop_wr)
                dc_wr_req <= 1'b0;
        end
    endtask

    initial
    begin
        void'($urandom(32'h5c0f));
        aclk       = 1'b0;
        aresetn    = 1'b0;
        ic_rd_req  = 1'b0;
        ic_rd_addr = '0;
        dc_rd_req  = 1'b0;
        dc_rd_addr = '0;
        dc_wr_req  = 1'b0;
        dc_wr      = '0;
        last_ar    = '1;
        last_aw    = '1;
        build_table();
        repeat (8) @(posedge aclk);
        aresetn <= 1'b1;
        for (entry_idx = 0; entry_idx < NUM_OPS; entry_idx++)
            run_entry(entry_idx, ops[entry_idx]);
        repeat (2) @(posedge aclk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
